//--- holo_bridge.f
+incdir+.
holo_bridge_pkg.sv
uart_rx.sv
uart_tx.sv
cmd_assembler.sv
spi_master.sv
resp_queue.sv
holo_bridge_top.sv
holo_bridge_assert.sv
tb_holo_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_holo_bridge \
  -f holo_bridge.f \
  -o tb_holo_bridge \
  && ./obj_dir/tb_holo_bridge > sim.log 2>&1 \
  ; cat sim.log \
  && grep -q "All checks passed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb_holo_bridge.sv
// directed testbench for the uart to spi bridge, one clock domain at 100 ns
// slave model assumes HB_SPI_HALF >= 2 so it can react between sck edges
`timescale 1ns/10ps
`include "holo_bridge_defs.svh"

module tb_holo_bridge import holo_bridge_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  localparam int CPB         = `HB_CLKS_PER_BIT;
  localparam int HALF        = `HB_SPI_HALF;
  localparam int RST_CYC     = `HB_SLM_RESET_CYCLES;
  // two rx bytes, one frame, one echo byte, plus slack
  localparam int PAIR_CYCLES = 32 * CPB + 40 * HALF + 50;
  // reset test, single, two multi, hard reset, eight random
  localparam int NUM_XFERS   = 13;

  logic fpga_clk;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic sout_i;
  logic uart_tx_o;
  logic sen_o;
  logic sck_o;
  logic sdat_o;
  logic slm_reset_n_o;

  // spi slave model state
  logic [15:0] miso_preload = '0;
  logic [15:0] miso_q       = '0;
  logic [15:0] mosi_q       = '0;
  logic [3:0]  slave_bits   = 4'd0;
  logic        sck_prev     = 1'b0;
  logic        sen_prev     = 1'b1;
  int          mosi_cnt     = 0;
  int          sen_falls    = 0;
  int          sen_rises    = 0;
  // slm reset pulse monitor
  int          rst_run       = 0;
  int          rst_pulse_len = 0;
  int          rst_pulse_cnt = 0;
  logic [31:0] lcg_state     = 32'd56;

  holo_bridge_top dut_i (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .sout_i          (sout_i),
    .uart_tx_o       (uart_tx_o),
    .sen_o           (sen_o),
    .sck_o           (sck_o),
    .sdat_o          (sdat_o),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  initial begin
    fpga_clk = 1'b0;
    forever #(CLK_PERIOD / 2) fpga_clk = ~fpga_clk;
  end

  //////////////////////////////
  // spi slave and pin monitors
  //////////////////////////////
  // msb of the miso word is always on the line
  assign sout_i = miso_q[15];

  always @(posedge fpga_clk) begin
    sck_prev <= sck_o;
    sen_prev <= sen_o;
    if (!reset_all_cmd_w) begin
      // rising sck, mosi is stable here
      if (!sck_prev && sck_o) begin
        mosi_q     <= {mosi_q[14:0], sdat_o};
        mosi_cnt   <= mosi_cnt + 1;
        slave_bits <= slave_bits + 4'd1;
      end
      // new frame or frame after a multi one gets a fresh miso word
      if (sen_prev && !sen_o) begin
        miso_q    <= miso_preload;
        sen_falls <= sen_falls + 1;
      end else if (sck_prev && !sck_o) begin
        miso_q <= (slave_bits == 4'd0) ? miso_preload : (miso_q << 1);
      end
      if (!sen_prev && sen_o) begin
        sen_rises <= sen_rises + 1;
      end
    end
  end

  // length of each low run on slm_reset_n_o, counted after reset
  always @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rst_run <= 0;
    end else if (!slm_reset_n_o) begin
      rst_run <= rst_run + 1;
    end else if (rst_run != 0) begin
      rst_pulse_len <= rst_run;
      rst_pulse_cnt <= rst_pulse_cnt + 1;
      rst_run       <= 0;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("Error: %s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  function automatic hb_byte_t lcg_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // 8N1, lsb first, each bit held for one bit time
  task automatic send_uart_byte(input hb_byte_t b);
    logic [9:0] frame_bits;
    frame_bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge fpga_clk);
      uart_rx_i <= frame_bits[i];
      repeat (CPB - 1) @(posedge fpga_clk);
    end
  endtask

  // samples each bit near its center
  task automatic recv_uart_byte(output hb_byte_t b);
    b = '0;
    @(posedge fpga_clk);
    while (uart_tx_o !== 1'b0) @(posedge fpga_clk);
    repeat (CPB / 2) @(posedge fpga_clk);
    assert (uart_tx_o === 1'b0) else abort_run("uart_tx_o start bit too short");
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(posedge fpga_clk);
      b[i] = uart_tx_o;
    end
    repeat (CPB) @(posedge fpga_clk);
    assert (uart_tx_o === 1'b1) else abort_run("uart_tx_o stop bit missing");
  endtask

  // returns just before the echo start bit can show up
  task automatic wait_frame(input int start_cnt);
    while (mosi_cnt < start_cnt + 16) @(posedge fpga_clk);
    repeat (HALF + 1) @(posedge fpga_clk);
  endtask

  task automatic pair_transfer(input hb_byte_t addr, input hb_byte_t data,
                               input logic [15:0] miso);
    int       start_cnt;
    int       rises;
    hb_byte_t echo;
    start_cnt    = mosi_cnt;
    rises        = sen_rises;
    miso_preload = miso;
    send_uart_byte(addr);
    send_uart_byte(data);
    wait_frame(start_cnt);
    assert (mosi_q == {addr, data})
      else value_mismatch("sdat_o frame", 32'(mosi_q), 32'({addr, data}));
    assert (sen_o === 1'b1 && sen_rises == rises + 1)
      else abort_run("sen_o did not return high after the frame");
    // data half of miso comes back
    recv_uart_byte(echo);
    assert (echo == miso[7:0])
      else value_mismatch("uart_tx_o echo", 32'(echo), 32'(miso[7:0]));
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic power_on_reset();
    reset_all_cmd_w <= 1'b1;
    @(posedge fpga_clk);
    repeat (2) begin
      @(posedge fpga_clk);
      assert (slm_reset_n_o === 1'b0)
        else value_mismatch("slm_reset_n_o in reset", 32'(slm_reset_n_o), 32'd0);
    end
    reset_all_cmd_w <= 1'b0;
    while (rst_pulse_cnt == 0) @(posedge fpga_clk);
    assert (rst_pulse_len == RST_CYC)
      else value_mismatch("slm_reset_n_o low cycles", 32'(rst_pulse_len), 32'(RST_CYC));
    assert (sen_o === 1'b1 && uart_tx_o === 1'b1)
      else abort_run("sen_o or uart_tx_o not idle high after reset");
  endtask

  // one frame plus its echo
  task automatic single_frame();
    pair_transfer(8'h5A, 8'hC3, 16'h96A5);
  endtask

  task automatic multi_frame();
    int       start_cnt;
    int       falls;
    int       rises;
    hb_byte_t echo;
    falls        = sen_falls;
    rises        = sen_rises;
    start_cnt    = mosi_cnt;
    miso_preload = 16'h3C5A;
    send_uart_byte(`HB_ADDR_MULTI);
    send_uart_byte(8'h81);
    wait_frame(start_cnt);
    assert (mosi_q == {`HB_ADDR_MULTI, 8'h81})
      else value_mismatch("sdat_o multi frame", 32'(mosi_q), 32'({`HB_ADDR_MULTI, 8'h81}));
    assert (sen_o === 1'b0) else abort_run("sen_o rose after a multi-byte frame");
    recv_uart_byte(echo);
    assert (echo == 8'h5A) else value_mismatch("uart_tx_o echo", 32'(echo), 32'h5A);
    // second frame reuses the same miso word
    start_cnt = mosi_cnt;
    send_uart_byte(8'h42);
    send_uart_byte(8'h7E);
    wait_frame(start_cnt);
    assert (mosi_q == 16'h427E)
      else value_mismatch("sdat_o second frame", 32'(mosi_q), 32'h427E);
    assert (sen_o === 1'b1 && sen_falls == falls + 1 && sen_rises == rises + 1)
      else abort_run("chip select did not stay low across the two frames");
    recv_uart_byte(echo);
    assert (echo == 8'h5A) else value_mismatch("uart_tx_o echo", 32'(echo), 32'h5A);
  endtask

  task automatic hard_reset_cmd();
    int start_cnt;
    int falls;
    int pulses;
    start_cnt = mosi_cnt;
    falls     = sen_falls;
    pulses    = rst_pulse_cnt;
    send_uart_byte(`HB_ADDR_HARD_RESET);
    send_uart_byte(8'h00);
    while (rst_pulse_cnt == pulses) @(posedge fpga_clk);
    assert (rst_pulse_len == RST_CYC)
      else value_mismatch("slm_reset_n_o low cycles", 32'(rst_pulse_len), 32'(RST_CYC));
    // longer than a whole frame would take
    repeat (40 * HALF) @(posedge fpga_clk);
    assert (mosi_cnt == start_cnt && sen_falls == falls && sen_o === 1'b1)
      else abort_run("spi activity after a hard-reset command");
  endtask

  task automatic random_pairs();
    hb_byte_t    addr;
    hb_byte_t    data;
    logic [15:0] miso;
    for (int n = 0; n < 8; n++) begin
      addr = lcg_byte();
      // keep clear of the special addresses
      if (addr == `HB_ADDR_MULTI || addr == `HB_ADDR_HARD_RESET) begin
        addr = addr ^ 8'h40;
      end
      data = lcg_byte();
      miso = {lcg_byte(), lcg_byte()};
      pair_transfer(addr, data, miso);
    end
  endtask

  //////////////////////////////
  // sequence and watchdog
  //////////////////////////////
  initial begin
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    power_on_reset();
    single_frame();
    multi_frame();
    hard_reset_cmd();
    random_pairs();
    repeat (10) @(posedge fpga_clk);
    $display("All checks passed");
    $finish;
  end

  initial begin
    #(NUM_XFERS * PAIR_CYCLES * CLK_PERIOD);
    $display("Error: timeout, the tests did not finish in time");
    $display("Checks failed");
    $fatal(1);
  end

endmodule

//--- holo_bridge_assert.sv
// req/ack handshake and spi pin checks, bound into the design
// pin checks only make sense where sen and sck are real
`timescale 1ns/10ps

module holo_bridge_assert import holo_bridge_pkg::*; #(
  parameter bit PIN_CHECKS = 1'b1
) (
  input logic     clk,
  input logic     rst,
  input logic     req,
  input logic     ack,
  input spi_cmd_t cmd,
  input logic     sen,
  input logic     sck
);

  // four-phase, req held until ack
  req_held: assert property (@(posedge clk) disable iff (rst) req && !ack |=> req)
    else $error("spi_req fell before spi_ack");

  // command frozen for the whole request
  cmd_stable: assert property (@(posedge clk) disable iff (rst) req |=> $stable(cmd))
    else $error("spi_cmd changed while spi_req high");

  ack_after_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
    else $error("spi_ack rose without spi_req");

  generate
    if (PIN_CHECKS) begin : g_pins
      // mode 0, clock idles low when deselected
      sck_idle: assert property (@(posedge clk) disable iff (rst) sen |-> !sck)
        else $error("sck_o high while sen_o high");
    end
  endgenerate

endmodule

bind spi_master holo_bridge_assert #(.PIN_CHECKS(1'b1)) u_spi_assert (
  .clk (fpga_clk), .rst (reset_all_cmd_w), .req (spi_req_i), .ack (spi_ack_o),
  .cmd (spi_cmd_i), .sen (sen_o), .sck (sck_o)
);

bind cmd_assembler holo_bridge_assert #(.PIN_CHECKS(1'b0)) u_asm_assert (
  .clk (fpga_clk), .rst (reset_all_cmd_w), .req (spi_req_o), .ack (spi_ack_i),
  .cmd (spi_cmd_o), .sen (1'b1), .sck (1'b0)
);

//--- holo_bridge_top.sv
// pc command bridge, uart in, spi to the slm, read-back out on uart
// single clock domain, reset_all_cmd_w synchronous and active high
`timescale 1ns/10ps

module holo_bridge_top import holo_bridge_pkg::*; (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  input  logic sout_i,
  output logic uart_tx_o,
  output logic sen_o,
  output logic sck_o,
  output logic sdat_o,
  output logic slm_reset_n_o
);

  uart_byte_t rx_byte;
  logic       spi_req;
  logic       spi_ack;
  spi_cmd_t   spi_cmd;
  uart_byte_t rd_byte;
  logic       tx_start;
  hb_byte_t   tx_byte;
  logic       tx_busy;

  //////////////////////////////
  // pc to slm
  //////////////////////////////
  uart_rx u_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .rx_byte_o       (rx_byte)
  );

  // pairs bytes, owns req side and slm reset
  cmd_assembler u_cmd_asm (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_byte_i       (rx_byte),
    .spi_ack_i       (spi_ack),
    .spi_req_o       (spi_req),
    .spi_cmd_o       (spi_cmd),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  spi_master u_spi (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_req_i       (spi_req),
    .spi_cmd_i       (spi_cmd),
    .sout_i          (sout_i),
    .spi_ack_o       (spi_ack),
    .sen_o           (sen_o),
    .sck_o           (sck_o),
    .sdat_o          (sdat_o),
    .rd_byte_o       (rd_byte)
  );

  //////////////////////////////
  // read-back to pc
  //////////////////////////////
  resp_queue u_resp_q (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rd_byte_i       (rd_byte),
    .tx_busy_i       (tx_busy),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx u_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .uart_tx_o       (uart_tx_o),
    .tx_busy_o       (tx_busy)
  );

endmodule

//--- resp_queue.sv
// circular queue of spi read-back bytes toward uart_tx
// bytes arriving while full are lost silently
`timescale 1ns/10ps
`include "holo_bridge_defs.svh"

module resp_queue import holo_bridge_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  uart_byte_t rd_byte_i,
  input  logic       tx_busy_i,
  output logic       tx_start_o,
  output hb_byte_t   tx_byte_o
);

  localparam int DEPTH = `HB_RESP_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  hb_byte_t      mem_q [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          tx_start_q;
  hb_byte_t      tx_byte_q;
  logic          push;
  logic          pop;

  // wrap for any depth, not just powers of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    ptr_inc = (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push = rd_byte_i.valid && (count_q != (AW + 1)'(DEPTH));
  // no pop while a start is in flight, busy shows up a cycle late
  assign pop  = (count_q != '0) && !tx_busy_i && !tx_start_q;

  always_ff @(posedge fpga_clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= rd_byte_i.data;
    end
    if (pop) begin
      tx_byte_q <= mem_q[rd_ptr_q];
    end
  end

  //////////////////////////////
  // pointers and count
  //////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      tx_start_q <= 1'b0;
    end else begin
      // pop this cycle, start the transmitter next
      tx_start_q <= pop;
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign tx_start_o = tx_start_q;
  assign tx_byte_o  = tx_byte_q;

endmodule

//--- spi_master.sv
// 16-bit mode-0 master, msb first, sck phase is HB_SPI_HALF clocks
// only the last 8 miso bits (data half) come back as rd_byte
`timescale 1ns/10ps
`include "holo_bridge_defs.svh"

module spi_master import holo_bridge_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       spi_req_i,
  input  spi_cmd_t   spi_cmd_i,
  input  logic       sout_i,
  output logic       spi_ack_o,
  output logic       sen_o,
  output logic       sck_o,
  output logic       sdat_o,
  output uart_byte_t rd_byte_o
);

  localparam int HALF = `HB_SPI_HALF;
  localparam int HW   = $clog2(HALF + 1);

  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_ACK} spi_state_t;

  spi_state_t    state_q;
  logic [HW-1:0] half_cnt_q;
  logic [3:0]    bit_cnt_q;
  logic [15:0]   tx_shift_q;
  hb_byte_t      rx_shift_q;
  logic          multi_q;
  logic          sen_q;
  logic          sck_q;
  logic          sdat_q;
  logic          ack_q;
  logic          rd_valid_q;
  hb_byte_t      rd_data_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= SPI_IDLE;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      sen_q      <= 1'b1;
      sck_q      <= 1'b0;
      sdat_q     <= 1'b0;
      ack_q      <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= 1'b0;
      case (state_q)
        SPI_IDLE: begin
          if (spi_req_i) begin
            // select, first bit set up while sck low
            sen_q      <= 1'b0;
            tx_shift_q <= spi_cmd_i.frame.raw;
            sdat_q     <= spi_cmd_i.frame.raw[15];
            multi_q    <= spi_cmd_i.multi;
            half_cnt_q <= '0;
            bit_cnt_q  <= '0;
            state_q    <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_cnt_q == HW'(HALF - 1)) begin
            half_cnt_q <= '0;
            sck_q      <= ~sck_q;
            if (!sck_q) begin
              // rising edge, sample miso
              rx_shift_q <= {rx_shift_q[6:0], sout_i};
            end else if (bit_cnt_q == 4'd15) begin
              // last falling edge, frame done
              sen_q      <= ~multi_q;
              ack_q      <= 1'b1;
              rd_valid_q <= 1'b1;
              rd_data_q  <= rx_shift_q;
              state_q    <= SPI_ACK;
            end else begin
              // falling edge, next mosi bit
              sdat_q     <= tx_shift_q[14];
              tx_shift_q <= tx_shift_q << 1;
              bit_cnt_q  <= bit_cnt_q + 1'b1;
            end
          end else begin
            half_cnt_q <= half_cnt_q + 1'b1;
          end
        end
        default: begin
          // hold ack until req drops
          if (!spi_req_i) begin
            ack_q   <= 1'b0;
            state_q <= SPI_IDLE;
          end
        end
      endcase
    end
  end

  assign spi_ack_o       = ack_q;
  assign sen_o           = sen_q;
  assign sck_o           = sck_q;
  assign sdat_o          = sdat_q;
  assign rd_byte_o.valid = rd_valid_q;
  assign rd_byte_o.data  = rd_data_q;

endmodule

//--- cmd_assembler.sv
// pairs rx bytes into addr/data frames, addr is the earlier byte
// a pair done while the spi handshake is open is dropped
// 0xbd never reaches spi, it only restarts the slm reset pulse
`timescale 1ns/10ps
`include "holo_bridge_defs.svh"

module cmd_assembler import holo_bridge_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  uart_byte_t rx_byte_i,
  input  logic       spi_ack_i,
  output logic       spi_req_o,
  output spi_cmd_t   spi_cmd_o,
  output logic       slm_reset_n_o
);

  localparam int RST_CYC = `HB_SLM_RESET_CYCLES;
  localparam int RW      = $clog2(RST_CYC + 1);

  spi_frame_u    pair_q;
  spi_frame_u    pair_next;
  logic          parity_q;
  logic          second_byte;
  logic          is_hard_reset;
  logic          hs_open;
  logic          send_frame;
  spi_cmd_t      cmd_q;
  logic          req_q;
  logic [RW-1:0] rst_cnt_q;
  logic          slm_rst_n_q;

  //////////////////////////////
  // byte pairing
  //////////////////////////////
  // old data moves up to addr, new byte becomes data
  always_comb begin
    pair_next.f.addr = pair_q.f.data;
    pair_next.f.data = rx_byte_i.data;
  end

  // parity high means this byte completes a pair
  assign second_byte   = rx_byte_i.valid && parity_q;
  assign is_hard_reset = (pair_next.f.addr == `HB_ADDR_HARD_RESET);
  // open from req rise until ack has fallen again
  assign hs_open       = req_q || spi_ack_i;
  assign send_frame    = second_byte && !is_hard_reset && !hs_open;

  always_ff @(posedge fpga_clk) begin
    if (rx_byte_i.valid) begin
      pair_q <= pair_next;
    end
  end

  // held for the whole handshake
  always_ff @(posedge fpga_clk) begin
    if (send_frame) begin
      cmd_q.frame <= pair_next;
      cmd_q.multi <= (pair_next.f.addr == `HB_ADDR_MULTI);
    end
  end

  //////////////////////////////
  // request side of req/ack
  //////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      parity_q <= 1'b0;
      req_q    <= 1'b0;
    end else begin
      if (rx_byte_i.valid) begin
        parity_q <= ~parity_q;
      end
      // drop req once ack seen, next req waits for ack low
      if (req_q && spi_ack_i) begin
        req_q <= 1'b0;
      end else if (send_frame) begin
        req_q <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // slm reset countdown
  //////////////////////////////
  // load one less than the pulse, the load cycle counts too
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w || (second_byte && is_hard_reset)) begin
      rst_cnt_q   <= RW'(RST_CYC - 1);
      slm_rst_n_q <= 1'b0;
    end else if (rst_cnt_q != '0) begin
      rst_cnt_q   <= rst_cnt_q - 1'b1;
      slm_rst_n_q <= 1'b0;
    end else begin
      slm_rst_n_q <= 1'b1;
    end
  end

  assign spi_req_o     = req_q;
  assign spi_cmd_o     = cmd_q;
  assign slm_reset_n_o = slm_rst_n_q;

endmodule

//--- uart_tx.sv
// 8N1 transmitter, start is ignored while busy
// busy covers the whole frame up to the end of the stop bit
`timescale 1ns/10ps
`include "holo_bridge_defs.svh"

module uart_tx import holo_bridge_pkg::*; (
  input  logic     fpga_clk,
  input  logic     reset_all_cmd_w,
  input  logic     tx_start_i,
  input  hb_byte_t tx_byte_i,
  output logic     uart_tx_o,
  output logic     tx_busy_o
);

  localparam int CPB = `HB_CLKS_PER_BIT;
  localparam int CW  = $clog2(CPB);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t     state_q;
  logic [CW-1:0] clk_cnt_q;
  logic [2:0]    bit_cnt_q;
  hb_byte_t      shift_q;
  logic          line_q;

  //////////////////////////////
  // bit sequencer
  //////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= TX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      line_q    <= 1'b1;
    end else begin
      case (state_q)
        TX_IDLE: begin
          line_q    <= 1'b1;
          clk_cnt_q <= '0;
          if (tx_start_i) begin
            shift_q <= tx_byte_i;
            // start bit
            line_q  <= 1'b0;
            state_q <= TX_START;
          end
        end
        TX_START: begin
          if (clk_cnt_q == CW'(CPB - 1)) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            line_q    <= shift_q[0];
            state_q   <= TX_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        TX_DATA: begin
          if (clk_cnt_q == CW'(CPB - 1)) begin
            clk_cnt_q <= '0;
            if (bit_cnt_q == 3'd7) begin
              // stop bit
              line_q  <= 1'b1;
              state_q <= TX_STOP;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              shift_q   <= shift_q >> 1;
              line_q    <= shift_q[1];
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          if (clk_cnt_q == CW'(CPB - 1)) begin
            state_q <= TX_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  assign uart_tx_o = line_q;
  assign tx_busy_o = (state_q != TX_IDLE);

endmodule

//--- uart_rx.sv
// 8N1 receiver, bit time from HB_CLKS_PER_BIT
// a bad stop bit drops the byte without any flag
`timescale 1ns/10ps
`include "holo_bridge_defs.svh"

module uart_rx import holo_bridge_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       uart_rx_i,
  output uart_byte_t rx_byte_o
);

  localparam int CPB = `HB_CLKS_PER_BIT;
  localparam int CW  = $clog2(CPB);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  logic [1:0]    sync_q;
  rx_state_t     state_q;
  logic [CW-1:0] clk_cnt_q;
  logic [2:0]    bit_cnt_q;
  hb_byte_t      shift_q;
  logic          valid_q;
  logic          line;

  // two-flop sync on the async pin
  assign line = sync_q[1];

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      sync_q    <= 2'b11;
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], uart_rx_i};
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          // falling edge, possible start bit
          if (!line) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (clk_cnt_q == CW'(CPB / 2 - 1)) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            // glitch shorter than half a bit goes back to idle
            state_q   <= line ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt_q == CW'(CPB - 1)) begin
            clk_cnt_q <= '0;
            // lsb first, fill from the top
            shift_q   <= {line, shift_q[7:1]};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          // middle of stop bit, strobe lands next cycle
          if (clk_cnt_q == CW'(CPB - 1)) begin
            clk_cnt_q <= '0;
            valid_q   <= line;
            state_q   <= RX_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  assign rx_byte_o.valid = valid_q;
  assign rx_byte_o.data  = shift_q;

endmodule

//--- holo_bridge_pkg.sv
// shared types for the uart to spi command path
// frame union relies on addr sitting in the high byte
package holo_bridge_pkg;

  // one uart or spi byte
  typedef logic [7:0] hb_byte_t;

  // field view of a frame, addr goes out first
  typedef struct packed {
    hb_byte_t addr;
    hb_byte_t data;
  } spi_fields_t;

  // same 16 bits, seen as fields or as the raw shift word
  typedef union packed {
    spi_fields_t f;
    logic [15:0] raw;
  } spi_frame_u;

  // one spi request
  // multi holds chip select low after the frame
  typedef struct packed {
    spi_frame_u frame;
    logic       multi;
  } spi_cmd_t;

  // byte plus one-cycle valid strobe
  typedef struct packed {
    logic     valid;
    hb_byte_t data;
  } uart_byte_t;

endpackage

//--- holo_bridge_defs.svh
// build-time constants for the PC command bridge
// uart and spi rates assume one fpga_clk domain; no runtime config
`ifndef HOLO_BRIDGE_DEFS_SVH
`define HOLO_BRIDGE_DEFS_SVH

//////////////////////////////
// uart
//////////////////////////////
// bit time in fpga_clk cycles
`define HB_CLKS_PER_BIT 20

//////////////////////////////
// spi and slm control
//////////////////////////////
// clocks per sck phase, full sck period is twice this
`define HB_SPI_HALF 2
// slm reset pulse length in cycles
`define HB_SLM_RESET_CYCLES 10
// read-back queue entries
`define HB_RESP_DEPTH 4

// special address bytes
// 0xbc keeps chip select low into the next frame
`define HB_ADDR_MULTI 8'hBC
// 0xbd pulses the slm reset line, no spi transfer
`define HB_ADDR_HARD_RESET 8'hBD

`endif
